//--- list.f
rx_pkg.sv
rx_wr_if.sv
rx_bar_xlate.sv
rx_tlp_decode.sv
rx_avl_wr_master.sv
rx_pndg_rd_fifo.sv
rx_bridge_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the receive bridge testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_top --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "SIMULATION PASSED" sim.log
echo "run.sh: pass message found"

//--- rx_avl_wr_master.sv
// Avalon-MM burst write master output stage with waitrequest holding
`timescale 1ns/1ps

module rx_avl_wr_master
#(
   parameter int AVL_ADDR_W = 32
)
(
   input  logic                         Clk_i,
   input  logic                         Rstn_i,
   rx_wr_if.snk                         wr,
   output logic                         rxm_write_o,
   output logic [AVL_ADDR_W-1:0]        rxm_address_o,
   output logic [rx_pkg::RX_DATA_W-1:0] rxm_write_data_o,
   output logic [rx_pkg::BURST_W-1:0]   rxm_burst_count_o,
   input  logic                         rxm_wait_request_i
);

   logic take_beat;

   // slot is free when empty or the slave takes the current beat this edge
   assign wr.ready  = ~rxm_write_o | ~rxm_wait_request_i;
   assign take_beat = wr.valid & wr.ready;

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
         rxm_write_o <= 1'b0;
      else if (wr.ready)
         rxm_write_o <= wr.valid;
   end

   always_ff @(posedge Clk_i)
   begin
      if (take_beat)
      begin
         rxm_address_o     <= wr.addr;
         rxm_write_data_o  <= wr.data;
         rxm_burst_count_o <= wr.burst;
      end
   end

   // held beat must not change until the slave releases waitrequest
   a_hold_on_wait: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      (rxm_write_o && rxm_wait_request_i)
      |=> (rxm_write_o && $stable(rxm_address_o) && $stable(rxm_write_data_o)));

endmodule

//--- rx_bar_xlate.sv
// BAR base/mask configuration registers and PCIe to Avalon address translation
`timescale 1ns/1ps

module rx_bar_xlate
#(
   parameter int AVL_ADDR_W = 32
)
(
   input  logic                           Clk_i,
   input  logic                           Rstn_i,
   input  logic                           cfg_wr_i,
   input  logic [1:0]                     cfg_addr_i,
   input  logic [rx_pkg::PCIE_ADDR_W-1:0] cfg_wdata_i,
   input  logic                           bar_idx_i,
   input  logic [rx_pkg::PCIE_ADDR_W-1:0] pcie_addr_i,
   output logic [AVL_ADDR_W-1:0]          avl_addr_o
);
   import rx_pkg::*;

   logic [PCIE_ADDR_W-1:0] base_q [NUM_BARS];
   logic [PCIE_ADDR_W-1:0] mask_q [NUM_BARS];
   logic [PCIE_ADDR_W-1:0] xl_sum;

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         base_q <= '{default: '0};
         mask_q <= '{default: '0};
      end
      else if (cfg_wr_i)
      begin
         case (cfg_addr_i)
            CFG_BASE0: base_q[0] <= cfg_wdata_i;
            CFG_MASK0: mask_q[0] <= cfg_wdata_i;
            CFG_BASE1: base_q[1] <= cfg_wdata_i;
            default:   mask_q[1] <= cfg_wdata_i;
         endcase
      end
   end

   // window offset kept by the mask, relocated onto the BAR base
   assign xl_sum     = base_q[bar_idx_i] + (pcie_addr_i & mask_q[bar_idx_i]);
   assign avl_addr_o = xl_sum[AVL_ADDR_W-1:0];

   a_cfg_addr_known: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      cfg_wr_i |-> !$isunknown(cfg_addr_i));

endmodule

//--- rx_bridge_top.sv
// receive bridge top level joining decoder, BAR translation, write master and read FIFO
`timescale 1ns/1ps

module rx_bridge_top
#(
   parameter int AVL_ADDR_W = 32,
   parameter int PNDG_DEPTH = 4
)
(
   input  logic                           Clk_i,
   input  logic                           Rstn_i,
   input  logic                           cfg_wr_i,
   input  logic [1:0]                     cfg_addr_i,
   input  logic [rx_pkg::PCIE_ADDR_W-1:0] cfg_wdata_i,
   input  logic                           rx_st_valid_i,
   input  logic [rx_pkg::RX_DATA_W-1:0]   rx_st_data_i,
   input  logic                           rx_st_sop_i,
   input  logic                           rx_st_eop_i,
   input  logic [rx_pkg::NUM_BARS-1:0]    rx_st_bar_hit_i,
   output logic                           rx_st_ready_o,
   output logic                           rxm_write_o,
   output logic [AVL_ADDR_W-1:0]          rxm_address_o,
   output logic [rx_pkg::RX_DATA_W-1:0]   rxm_write_data_o,
   output logic [rx_pkg::BURST_W-1:0]     rxm_burst_count_o,
   input  logic                           rxm_wait_request_i,
   output logic                           pndg_rd_valid_o,
   input  logic                           pndg_rd_ready_i,
   output logic [rx_pkg::REQ_ID_W-1:0]    pndg_rd_req_id_o,
   output logic [rx_pkg::TAG_W-1:0]       pndg_rd_tag_o,
   output logic [rx_pkg::LEN_W-1:0]       pndg_rd_len_o,
   output logic [AVL_ADDR_W-1:0]          pndg_rd_addr_o
);
   import rx_pkg::*;

   logic                   bar_idx;
   logic [PCIE_ADDR_W-1:0] pcie_addr;
   logic [AVL_ADDR_W-1:0]  avl_addr;
   logic                   rd_valid;
   logic                   rd_ready;
   pndg_rd_t               rd_hdr;
   pndg_rd_t               pop_hdr;

   rx_wr_if #(.AVL_ADDR_W(AVL_ADDR_W)) wr_link ();

   rx_tlp_decode #(.AVL_ADDR_W(AVL_ADDR_W)) u_decode (
      .Clk_i, .Rstn_i,
      .rx_st_valid_i, .rx_st_sop_i, .rx_st_eop_i, .rx_st_data_i, .rx_st_bar_hit_i,
      .rx_st_ready_o,
      .bar_idx_o (bar_idx), .pcie_addr_o (pcie_addr), .avl_addr_i (avl_addr),
      .wr (wr_link.src),
      .rd_valid_o (rd_valid), .rd_ready_i (rd_ready), .rd_hdr_o (rd_hdr)
   );

   rx_bar_xlate #(.AVL_ADDR_W(AVL_ADDR_W)) u_xlate (
      .Clk_i, .Rstn_i, .cfg_wr_i, .cfg_addr_i, .cfg_wdata_i,
      .bar_idx_i (bar_idx), .pcie_addr_i (pcie_addr), .avl_addr_o (avl_addr)
   );

   rx_avl_wr_master #(.AVL_ADDR_W(AVL_ADDR_W)) u_wr_master (
      .Clk_i, .Rstn_i, .wr (wr_link.snk),
      .rxm_write_o, .rxm_address_o, .rxm_write_data_o, .rxm_burst_count_o,
      .rxm_wait_request_i
   );

   rx_pndg_rd_fifo #(.PNDG_DEPTH(PNDG_DEPTH)) u_rd_fifo (
      .Clk_i, .Rstn_i,
      .push_valid_i (rd_valid), .push_ready_o (rd_ready), .push_hdr_i (rd_hdr),
      .pop_valid_o (pndg_rd_valid_o), .pop_ready_i (pndg_rd_ready_i), .pop_hdr_o (pop_hdr)
   );

   // header fields out to the transmit side
   assign pndg_rd_req_id_o = pop_hdr.req_id;
   assign pndg_rd_tag_o    = pop_hdr.tag;
   assign pndg_rd_len_o    = pop_hdr.len;
   assign pndg_rd_addr_o   = pop_hdr.addr[AVL_ADDR_W-1:0];

endmodule

//--- rx_pkg.sv
// bus widths, packet format codes, pending-read header type and config register indices
package rx_pkg;

   // stream and address widths
   localparam int RX_DATA_W   = 64;
   localparam int PCIE_ADDR_W = 32;
   localparam int BURST_W     = 7;
   localparam int LEN_W       = 10;
   localparam int TAG_W       = 8;
   localparam int REQ_ID_W    = 16;
   localparam int NUM_BARS    = 2;

   // format/type byte of header beat 0
   localparam logic [7:0] FMT_MWR32 = 8'h40;
   localparam logic [7:0] FMT_MRD32 = 8'h00;

   typedef enum logic [1:0]
   {
      TLP_WR    = 2'd0,
      TLP_RD    = 2'd1,
      TLP_OTHER = 2'd2
   } tlp_kind_e;

   // one queued read request, address already translated
   typedef struct packed
   {
      logic [REQ_ID_W-1:0]    req_id;
      logic [TAG_W-1:0]       tag;
      logic [LEN_W-1:0]       len;
      logic [PCIE_ADDR_W-1:0] addr;
   } pndg_rd_t;

   // configuration register map
   localparam logic [1:0] CFG_BASE0 = 2'd0;
   localparam logic [1:0] CFG_MASK0 = 2'd1;
   localparam logic [1:0] CFG_BASE1 = 2'd2;
   localparam logic [1:0] CFG_MASK1 = 2'd3;

endpackage

//--- rx_pndg_rd_fifo.sv
// pending read header FIFO, first word fall through
`timescale 1ns/1ps

module rx_pndg_rd_fifo
#(
   parameter int PNDG_DEPTH = 4
)
(
   input  logic             Clk_i,
   input  logic             Rstn_i,
   input  logic             push_valid_i,
   output logic             push_ready_o,
   input  rx_pkg::pndg_rd_t push_hdr_i,
   output logic             pop_valid_o,
   input  logic             pop_ready_i,
   output rx_pkg::pndg_rd_t pop_hdr_o
);
   import rx_pkg::*;

   localparam int PTR_W = $clog2(PNDG_DEPTH);
   localparam int CNT_W = $clog2(PNDG_DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(PNDG_DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(PNDG_DEPTH);

   pndg_rd_t         mem [PNDG_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   assign push_ready_o = (count_q != FULL_CNT);
   assign pop_valid_o  = (count_q != '0);
   assign pop_hdr_o    = mem[rd_ptr_q];
   assign push         = push_valid_i & push_ready_o;
   assign pop          = pop_valid_o & pop_ready_i;

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
         count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
      end
   end

   always_ff @(posedge Clk_i)
   begin
      if (push)
         mem[wr_ptr_q] <= push_hdr_i;
   end

   // while full and nothing leaves, no new header may be written
   a_no_push_full: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      (count_q == FULL_CNT && !pop) |=> $stable(wr_ptr_q) && count_q == FULL_CNT);

endmodule

//--- rx_tlp_decode.sv
// receive packet framing FSM and header decoder routing writes and reads
`timescale 1ns/1ps

module rx_tlp_decode
#(
   parameter int AVL_ADDR_W = 32
)
(
   input  logic                           Clk_i,
   input  logic                           Rstn_i,
   input  logic                           rx_st_valid_i,
   input  logic                           rx_st_sop_i,
   input  logic                           rx_st_eop_i,
   input  logic [rx_pkg::RX_DATA_W-1:0]   rx_st_data_i,
   input  logic [rx_pkg::NUM_BARS-1:0]    rx_st_bar_hit_i,
   output logic                           rx_st_ready_o,
   output logic                           bar_idx_o,
   output logic [rx_pkg::PCIE_ADDR_W-1:0] pcie_addr_o,
   input  logic [AVL_ADDR_W-1:0]          avl_addr_i,
   rx_wr_if.src                           wr,
   output logic                           rd_valid_o,
   input  logic                           rd_ready_i,
   output rx_pkg::pndg_rd_t               rd_hdr_o
);
   import rx_pkg::*;

   typedef enum logic [1:0] {ST_HDR0, ST_HDR1, ST_PAYLOAD, ST_DISCARD} state_e;

   state_e                 state_q;
   state_e                 state_d;
   tlp_kind_e              hdr_kind;
   tlp_kind_e              kind_q;
   logic [LEN_W-1:0]       len_q;
   logic [TAG_W-1:0]       tag_q;
   logic [REQ_ID_W-1:0]    req_id_q;
   logic                   bar_q;
   logic [AVL_ADDR_W-1:0]  burst_addr_q;
   logic [BURST_W-1:0]     burst_q;
   logic                   rst_done_q;
   logic                   stream_rdy;
   logic                   beat_fire;

   always_comb
   begin
      case (rx_st_data_i[31:24])
         FMT_MWR32: hdr_kind = TLP_WR;
         FMT_MRD32: hdr_kind = TLP_RD;
         default:   hdr_kind = TLP_OTHER;
      endcase
   end

   // stall only on a read header with a full FIFO or a payload beat the master can't take
   always_comb
   begin
      case (state_q)
         ST_HDR1:    stream_rdy = (kind_q == TLP_RD) ? rd_ready_i : 1'b1;
         ST_PAYLOAD: stream_rdy = wr.ready;
         default:    stream_rdy = 1'b1;
      endcase
   end

   assign rx_st_ready_o = rst_done_q & stream_rdy;
   assign beat_fire     = rx_st_valid_i & rx_st_ready_o;

   always_comb
   begin
      state_d = state_q;
      if (beat_fire)
      begin
         case (state_q)
            ST_HDR0: if (!rx_st_eop_i) state_d = ST_HDR1;
            ST_HDR1:
            begin
               if (rx_st_eop_i)
                  state_d = ST_HDR0;
               else if (kind_q == TLP_WR)
                  state_d = ST_PAYLOAD;
               else
                  state_d = ST_DISCARD;
            end
            default: if (rx_st_eop_i) state_d = ST_HDR0;
         endcase
      end
   end

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         state_q    <= ST_HDR0;
         rst_done_q <= 1'b0;
      end
      else
      begin
         state_q    <= state_d;
         rst_done_q <= 1'b1;
      end
   end

   // header fields, captured on the beat they arrive in
   always_ff @(posedge Clk_i)
   begin
      if (beat_fire && state_q == ST_HDR0)
      begin
         kind_q   <= hdr_kind;
         len_q    <= rx_st_data_i[LEN_W-1:0];
         tag_q    <= rx_st_data_i[47:40];
         req_id_q <= rx_st_data_i[63:48];
         bar_q    <= rx_st_bar_hit_i[1];
      end
      if (beat_fire && state_q == ST_HDR1 && kind_q == TLP_WR)
      begin
         burst_addr_q <= avl_addr_i;
         burst_q      <= len_q[BURST_W:1];
      end
   end

   // translation sees the address while header beat 1 is on the bus
   assign bar_idx_o   = bar_q;
   assign pcie_addr_o = rx_st_data_i[PCIE_ADDR_W-1:0];

   assign wr.valid = rx_st_valid_i & (state_q == ST_PAYLOAD);
   assign wr.addr  = burst_addr_q;
   assign wr.burst = burst_q;
   assign wr.data  = rx_st_data_i;

   assign rd_valid_o      = rx_st_valid_i & (state_q == ST_HDR1) & (kind_q == TLP_RD);
   assign rd_hdr_o.req_id = req_id_q;
   assign rd_hdr_o.tag    = tag_q;
   assign rd_hdr_o.len    = len_q;
   assign rd_hdr_o.addr   = PCIE_ADDR_W'(avl_addr_i);

   a_sop_in_hdr0: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      (rx_st_valid_i && rx_st_ready_o && rx_st_sop_i) |-> state_q == ST_HDR0);

endmodule

//--- rx_wr_if.sv
// write beat link between packet decoder and Avalon write master
`timescale 1ns/1ps

interface rx_wr_if
#(
   parameter int AVL_ADDR_W = 32
);
   import rx_pkg::*;

   logic                  valid;
   logic                  ready;
   logic [AVL_ADDR_W-1:0] addr;
   logic [BURST_W-1:0]    burst;
   logic [RX_DATA_W-1:0]  data;

   // decoder side
   modport src
   (
      output valid, addr, burst, data,
      input  ready
   );

   // master side
   modport snk
   (
      input  valid, addr, burst, data,
      output ready
   );

endinterface

//--- tb_checker.sv
// monitor of stream ready, the Avalon write port and the pending-read port with expected queues
`timescale 1ns/1ps

module tb_checker
(
   input logic        Clk_i,
   input logic        Rstn_i,
   input logic        rx_st_ready_i,
   input logic        rxm_write_i,
   input logic [31:0] rxm_address_i,
   input logic [63:0] rxm_write_data_i,
   input logic [6:0]  rxm_burst_count_i,
   input logic        rxm_wait_request_i,
   input logic        pndg_rd_valid_i,
   input logic        pndg_rd_ready_i,
   input logic [15:0] pndg_rd_req_id_i,
   input logic [7:0]  pndg_rd_tag_i,
   input logic [9:0]  pndg_rd_len_i,
   input logic [31:0] pndg_rd_addr_i
);

   // {addr, burst, data} and {req_id, tag, len, addr}
   logic [102:0] wr_q [$];
   logic [65:0]  rd_q [$];
   int           err_count = 0;
   logic         held_q = 1'b0;
   logic         rst_seen_q = 1'b0;
   logic [95:0]  held_beat;

   task automatic expect_write(input logic [31:0] addr, input logic [6:0] burst,
                               input logic [63:0] data);
      wr_q.push_back({addr, burst, data});
   endtask

   task automatic expect_read(input logic [15:0] req_id, input logic [7:0] tag,
                              input logic [9:0] len, input logic [31:0] addr);
      rd_q.push_back({req_id, tag, len, addr});
   endtask

   function automatic int pending_count();
      return wr_q.size() + rd_q.size();
   endfunction

   task automatic compare_field(input string name, input logic [63:0] exp_val,
                                input logic [63:0] act_val);
      if (act_val !== exp_val)
      begin
         $display("Mismatch %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
         err_count++;
      end
   endtask

   always @(posedge Clk_i)
   begin
      logic [102:0] wr_exp;
      logic [65:0]  rd_exp;
      if (!Rstn_i)
      begin
         // outputs must be idle on every reset edge after the first
         if (rst_seen_q)
         begin
            compare_field("rx_st_ready_o", 64'h0, 64'(rx_st_ready_i));
            compare_field("rxm_write_o", 64'h0, 64'(rxm_write_i));
            compare_field("pndg_rd_valid_o", 64'h0, 64'(pndg_rd_valid_i));
         end
         rst_seen_q <= 1'b1;
         held_q     <= 1'b0;
      end
      else
      begin
         // a stalled beat must still be there one edge later
         if (held_q && {rxm_write_i, rxm_address_i, rxm_write_data_i} !== {1'b1, held_beat})
         begin
            $display("Mismatch rxm_write_o/rxm_address_o/rxm_write_data_o expected %h actual %h",
                     {1'b1, held_beat}, {rxm_write_i, rxm_address_i, rxm_write_data_i});
            err_count++;
         end
         if (rxm_write_i && !rxm_wait_request_i)
         begin
            if (wr_q.size() == 0)
            begin
               $display("Error: Avalon write beat at %0t when no write was expected", $time);
               err_count++;
            end
            else
            begin
               wr_exp = wr_q.pop_front();
               compare_field("rxm_address_o", 64'(wr_exp[102:71]), 64'(rxm_address_i));
               compare_field("rxm_burst_count_o", 64'(wr_exp[70:64]), 64'(rxm_burst_count_i));
               compare_field("rxm_write_data_o", wr_exp[63:0], rxm_write_data_i);
            end
         end
         if (pndg_rd_valid_i && pndg_rd_ready_i)
         begin
            if (rd_q.size() == 0)
            begin
               $display("Error: pending read header at %0t when no read was expected", $time);
               err_count++;
            end
            else
            begin
               rd_exp = rd_q.pop_front();
               compare_field("pndg_rd_req_id_o", 64'(rd_exp[65:50]), 64'(pndg_rd_req_id_i));
               compare_field("pndg_rd_tag_o", 64'(rd_exp[49:42]), 64'(pndg_rd_tag_i));
               compare_field("pndg_rd_len_o", 64'(rd_exp[41:32]), 64'(pndg_rd_len_i));
               compare_field("pndg_rd_addr_o", 64'(rd_exp[31:0]), 64'(pndg_rd_addr_i));
            end
         end
         held_q    <= rxm_write_i & rxm_wait_request_i;
         held_beat <= {rxm_address_i, rxm_write_data_i};
      end
   end

endmodule

//--- tb_clk_gen.sv
// testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clk_gen
#(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 16
)
(
   output logic Clk_o,
   output logic Rstn_o
);

   logic clk_q = 1'b0;
   logic rstn_q = 1'b0;

   always #(PERIOD_NS / 2) clk_q = ~clk_q;

   // release reset away from the rising edge
   initial
   begin
      repeat (RST_CYCLES) @(posedge clk_q);
      @(negedge clk_q);
      rstn_q = 1'b1;
   end

   assign Clk_o  = clk_q;
   assign Rstn_o = rstn_q;

endmodule

//--- tb_top.sv
// testbench top with stimulus table, drive loop, back-pressure, watchdog and report
`timescale 1ns/1ps

module tb_top;
   import rx_pkg::*;

   localparam int PERIOD_NS  = 40;
   localparam int NUM_ROWS   = 12;
   // longest packet in the table has two header beats and four payload beats
   localparam int MAX_BEATS  = 6;
   localparam int WATCHDOG_NS = (32 + NUM_ROWS * (MAX_BEATS + 40)) * PERIOD_NS;

   localparam logic [31:0] BASE0 = 32'h8000_0000;
   localparam logic [31:0] MASK0 = 32'h0000_0FFF;
   localparam logic [31:0] BASE1 = 32'h4000_0000;
   localparam logic [31:0] MASK1 = 32'h0000_FFFF;

   typedef struct packed
   {
      tlp_kind_e   kind;
      logic [1:0]  bar_hit;
      logic [31:0] addr;
      logic [9:0]  len;
      logic [7:0]  tag;
      logic [15:0] req_id;
      logic [63:0] seed;
      logic        hold;
   } row_t;

   logic        clk;
   logic        rstn;
   logic        cfg_wr;
   logic [1:0]  cfg_addr;
   logic [31:0] cfg_wdata;
   logic        rx_st_valid;
   logic [63:0] rx_st_data;
   logic        rx_st_sop;
   logic        rx_st_eop;
   logic [1:0]  rx_st_bar_hit;
   logic        rx_st_ready;
   logic        rxm_write;
   logic [31:0] rxm_address;
   logic [63:0] rxm_write_data;
   logic [6:0]  rxm_burst_count;
   logic        rxm_wait_req;
   logic        pndg_rd_valid;
   logic        pndg_rd_ready;
   logic [15:0] pndg_rd_req_id;
   logic [7:0]  pndg_rd_tag;
   logic [9:0]  pndg_rd_len;
   logic [31:0] pndg_rd_addr;
   logic        hold_rd;
   int          stall_cycles;

   tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(16)) clk_gen (.Clk_o(clk), .Rstn_o(rstn));

   rx_bridge_top #(.AVL_ADDR_W(32), .PNDG_DEPTH(4)) dut (
      .Clk_i (clk), .Rstn_i (rstn),
      .cfg_wr_i (cfg_wr), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
      .rx_st_valid_i (rx_st_valid), .rx_st_data_i (rx_st_data), .rx_st_sop_i (rx_st_sop),
      .rx_st_eop_i (rx_st_eop), .rx_st_bar_hit_i (rx_st_bar_hit), .rx_st_ready_o (rx_st_ready),
      .rxm_write_o (rxm_write), .rxm_address_o (rxm_address),
      .rxm_write_data_o (rxm_write_data), .rxm_burst_count_o (rxm_burst_count),
      .rxm_wait_request_i (rxm_wait_req),
      .pndg_rd_valid_o (pndg_rd_valid), .pndg_rd_ready_i (pndg_rd_ready),
      .pndg_rd_req_id_o (pndg_rd_req_id), .pndg_rd_tag_o (pndg_rd_tag),
      .pndg_rd_len_o (pndg_rd_len), .pndg_rd_addr_o (pndg_rd_addr)
   );

   tb_checker chk (
      .Clk_i (clk), .Rstn_i (rstn), .rx_st_ready_i (rx_st_ready),
      .rxm_write_i (rxm_write), .rxm_address_i (rxm_address),
      .rxm_write_data_i (rxm_write_data), .rxm_burst_count_i (rxm_burst_count),
      .rxm_wait_request_i (rxm_wait_req),
      .pndg_rd_valid_i (pndg_rd_valid), .pndg_rd_ready_i (pndg_rd_ready),
      .pndg_rd_req_id_i (pndg_rd_req_id), .pndg_rd_tag_i (pndg_rd_tag),
      .pndg_rd_len_i (pndg_rd_len), .pndg_rd_addr_i (pndg_rd_addr)
   );

   // base plus masked PCIe address through BAR 1 when hit bit 1 is set and BAR 0 otherwise
   function automatic logic [31:0] translate(input logic [1:0] bar_hit, input logic [31:0] addr);
      if (bar_hit[1])
         return BASE1 + (addr & MASK1);
      return BASE0 + (addr & MASK0);
   endfunction

   task automatic write_cfg(input logic [1:0] idx, input logic [31:0] value);
      @(negedge clk);
      cfg_wr    <= 1'b1;
      cfg_addr  <= idx;
      cfg_wdata <= value;
      @(negedge clk);
      cfg_wr    <= 1'b0;
   endtask

   // random slave stalls and transmit-side ready that stays low until a full FIFO held the stream
   task automatic drive_backpressure();
      forever
      begin
         @(negedge clk);
         if (hold_rd && rx_st_valid && !rx_st_ready)
            stall_cycles++;
         if (stall_cycles >= 8)
            hold_rd = 1'b0;
         rxm_wait_req  <= ($urandom % 4) == 0;
         pndg_rd_ready <= !hold_rd && (($urandom % 3) != 0);
      end
   endtask

   task automatic send_beat(input logic [63:0] data, input logic sop, input logic eop,
                            input logic [1:0] bar_hit);
      int gap;
      gap = $urandom % 3;
      repeat (gap)
      begin
         @(negedge clk);
         rx_st_valid <= 1'b0;
      end
      @(negedge clk);
      rx_st_valid   <= 1'b1;
      rx_st_data    <= data;
      rx_st_sop     <= sop;
      rx_st_eop     <= eop;
      rx_st_bar_hit <= bar_hit;
      @(posedge clk);
      while (!rx_st_ready)
         @(posedge clk);
   endtask

   task automatic send_packet(input row_t r);
      logic [7:0]  fmt;
      logic [63:0] hdr0;
      int          n_pay;
      fmt   = (r.kind == TLP_WR) ? FMT_MWR32 : (r.kind == TLP_RD) ? FMT_MRD32 : 8'h4A;
      n_pay = (r.kind == TLP_RD) ? 0 : r.len / 2;
      hdr0  = {r.req_id, r.tag, 8'h00, fmt, 14'h0, r.len};
      send_beat(hdr0, 1'b1, 1'b0, r.bar_hit);
      send_beat({32'h0, r.addr}, 1'b0, n_pay == 0, r.bar_hit);
      for (int k = 0; k < n_pay; k++)
         send_beat(r.seed + 64'(k), 1'b0, k == n_pay - 1, r.bar_hit);
      @(negedge clk);
      rx_st_valid <= 1'b0;
      @(posedge clk);
   endtask

   task automatic set_expectations(input row_t r);
      logic [31:0] avl;
      avl = translate(r.bar_hit, r.addr);
      if (r.kind == TLP_WR)
         for (int k = 0; k < r.len / 2; k++)
            chk.expect_write(avl, 7'(r.len / 2), r.seed + 64'(k));
      else if (r.kind == TLP_RD)
         chk.expect_read(r.req_id, r.tag, r.len, avl);
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: expected outputs or FIFO stall did not arrive within %0d ns",
               WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial
   begin
      row_t      rows [NUM_ROWS];
      tlp_kind_e kind;
      int        err_before;
      int        pass_rows;
      int        fail_rows;
      void'($urandom(44139));
      cfg_wr        = 1'b0;
      cfg_addr      = 2'd0;
      cfg_wdata     = 32'h0;
      rx_st_valid   = 1'b0;
      rx_st_data    = 64'h0;
      rx_st_sop     = 1'b0;
      rx_st_eop     = 1'b0;
      rx_st_bar_hit = 2'b00;
      rxm_wait_req  = 1'b0;
      pndg_rd_ready = 1'b0;
      hold_rd       = 1'b0;
      stall_cycles  = 0;
      pass_rows     = 0;
      fail_rows     = 0;
      // kind, bar hit, address, length, tag, requester, data seed, hold read ready
      rows = '{
         '{TLP_WR,    2'b01, 32'hF000_0100, 10'd4,  8'h01, 16'h0100, 64'hA000_0000_0000_0000, 1'b0},
         '{TLP_WR,    2'b10, 32'hF123_2040, 10'd8,  8'h02, 16'h0100, 64'hB000_0000_0000_0010, 1'b0},
         '{TLP_RD,    2'b01, 32'hF000_0480, 10'd2,  8'h03, 16'h0200, 64'h0,                   1'b0},
         '{TLP_RD,    2'b10, 32'hF123_1008, 10'd16, 8'h04, 16'h0201, 64'h0,                   1'b0},
         '{TLP_OTHER, 2'b01, 32'hF000_0200, 10'd4,  8'h05, 16'h0300, 64'hC000_0000_0000_0000, 1'b0},
         '{TLP_WR,    2'b01, 32'hF000_0800, 10'd6,  8'h06, 16'h0100, 64'hD000_0000_0000_0100, 1'b0},
         '{TLP_RD,    2'b01, 32'h0000_0010, 10'd2,  8'h10, 16'h0400, 64'h0,                   1'b1},
         '{TLP_RD,    2'b10, 32'h0000_3020, 10'd4,  8'h11, 16'h0401, 64'h0,                   1'b1},
         '{TLP_RD,    2'b01, 32'h0000_0F38, 10'd6,  8'h12, 16'h0402, 64'h0,                   1'b1},
         '{TLP_RD,    2'b10, 32'h1234_5678, 10'd8,  8'h13, 16'h0403, 64'h0,                   1'b1},
         '{TLP_RD,    2'b01, 32'h0000_0AA0, 10'd1,  8'h14, 16'h0404, 64'h0,                   1'b1},
         '{TLP_WR,    2'b10, 32'hF000_3000, 10'd8,  8'h20, 16'h0100, 64'hE000_0000_0000_0200, 1'b0}
      };
      fork
         drive_backpressure();
      join_none
      wait (rstn);
      write_cfg(CFG_BASE0, BASE0);
      write_cfg(CFG_MASK0, MASK0);
      write_cfg(CFG_BASE1, BASE1);
      write_cfg(CFG_MASK1, MASK1);
      @(posedge clk);
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         err_before = chk.err_count;
         kind       = rows[i].kind;
         // a held group keeps the FIFO from draining until the stream has stalled
         if (rows[i].hold && !hold_rd)
         begin
            stall_cycles = 0;
            hold_rd      = 1'b1;
         end
         set_expectations(rows[i]);
         send_packet(rows[i]);
         if (!rows[i].hold)
            while (chk.pending_count() != 0 || hold_rd)
               @(posedge clk);
         if (chk.err_count == err_before)
            pass_rows++;
         else
            fail_rows++;
         $display("row %0d %s done, %0d errors", i, kind.name(), chk.err_count - err_before);
      end
      // stray beats after the last packet still count
      repeat (10) @(posedge clk);
      $display("rows passed %0d, rows failed %0d, errors %0d",
               pass_rows, fail_rows, chk.err_count);
      if (fail_rows == 0 && chk.err_count == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule
